// File: source/cnn_pkg.sv
//====================================================================
// shared sizes, widths and memory port types of the convolution engine
// every rtl module pulls what it needs through a wildcard import
//====================================================================
package cnn_pkg;

  //====================================================================
  // geometry
  //====================================================================
  localparam int IMG_ROWS  = 8;                       // picture rows
  localparam int IMG_COLS  = 8;                       // picture cols, row pitch in bytes
  localparam int KER_ROWS  = 4;
  localparam int KER_COLS  = 4;                       // also the dot product depth
  localparam int WIN_ROWS  = IMG_ROWS - KER_ROWS + 1; // stride 1
  localparam int WIN_COLS  = IMG_COLS - KER_COLS + 1;
  localparam int NUM_OUT   = WIN_ROWS * WIN_COLS;     // output bytes per run
  localparam int WR_BYTES  = 4;                       // output bytes per write word

  // bus widths
  localparam int ADDR_W    = 19;
  localparam int RD_DATA_W = 128;

  //====================================================================
  // scalar types
  //====================================================================
  typedef logic        [ADDR_W-1:0]            addr_t;     // byte address
  typedef logic        [7:0]                   pix_t;      // picture byte
  typedef logic signed [7:0]                   wgt_t;      // kernel weight
  typedef logic signed [31:0]                  acc_t;      // sums and bias
  typedef logic        [$clog2(KER_ROWS)-1:0]  row_idx_t;  // row inside the kernel
  typedef logic        [2:0]                   win_idx_t;  // window x or y

  //====================================================================
  // memory ports
  //====================================================================
  typedef struct packed {
    logic  req;          // held until valid
    addr_t start_addr;
    addr_t size_bytes;
  } mem_rd_req_t;

  typedef struct packed {
    logic                 valid;  // single cycle
    logic [RD_DATA_W-1:0] data;   // byte 0 in the low bits
  } mem_rd_rsp_t;

  typedef struct packed {
    logic                  req;   // held until ack
    addr_t                 start_addr;
    addr_t                 size_bytes;
    logic [8*WR_BYTES-1:0] data;
  } mem_wr_req_t;

  // run sequencing
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    LOAD  = 3'd1,   // weight and bias fetch
    READ  = 3'd2,   // one picture row
    CALC  = 3'd3,   // accumulate the row
    ACT   = 3'd4,   // activation, byte push
    WRITE = 3'd5    // one output word
  } cnn_state_t;

endpackage

// File: source/dot_product.sv
//====================================================================
// four lane dot product of unsigned pixels and signed weights
// result appears one clock after the operands
//====================================================================
module dot_product import cnn_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  pix_t [KER_COLS-1:0] pix_row,
  input  wgt_t [KER_COLS-1:0] wgt_row,
  output acc_t                dp_res
);

  acc_t sum;

  always_comb
  begin
    logic signed [16:0] prod;   // 9 bit signed pixel times 8 bit weight
    sum = '0;
    for (int i = 0; i < KER_COLS; i++)
    begin
      prod = $signed({1'b0, pix_row[i]}) * $signed(wgt_row[i]);  // zero extend pixel
      sum  = sum + prod;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      dp_res <= '0;
    else
      dp_res <= sum;
  end

endmodule

// File: source/window_counter.sv
//====================================================================
// kernel row and window position tracking
// steps the kernel row after each CALC, moves the window in ACT and
// forms the byte address of the next picture row read
//====================================================================
module window_counter import cnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  cnn_state_t state,
  input  addr_t      sw_cnn_addr_x,
  output addr_t      pic_addr,
  output row_idx_t   kernel_row,
  output logic       last_row,
  output logic       last_window
);

  win_idx_t win_col;    // window x
  win_idx_t win_row;    // window y
  addr_t    pic_row;    // picture row under the current kernel row
  logic     last_col;

  assign last_row    = (kernel_row == row_idx_t'(KER_ROWS - 1));
  assign last_col    = (win_col == win_idx_t'(WIN_COLS - 1));
  assign last_window = last_col && (win_row == win_idx_t'(WIN_ROWS - 1));

  // row major picture, one row is IMG_COLS bytes
  assign pic_row  = addr_t'(win_row) + addr_t'(kernel_row);
  assign pic_addr = sw_cnn_addr_x + addr_t'(pic_row * IMG_COLS) + addr_t'(win_col);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      kernel_row <= '0;
      win_col    <= '0;
      win_row    <= '0;
    end
    else if (state == IDLE)
    begin
      kernel_row <= '0;
      win_col    <= '0;
      win_row    <= '0;
    end
    else
    begin
      if (state == CALC)
        kernel_row <= last_row ? '0 : kernel_row + 1'b1;
      if (state == ACT)
      begin
        if (last_col)
        begin
          win_col <= '0;               // next window line
          win_row <= win_row + 1'b1;   // runs past the end only on the last window
        end
        else
          win_col <= win_col + 1'b1;
      end
    end
  end

endmodule

// File: source/conv_accum.sv
//====================================================================
// weight and bias storage, row accumulation and activation
// the accumulator collects four row products per window, bias is
// added and the sum clamped to one unsigned output byte
//====================================================================
module conv_accum import cnn_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  cnn_state_t  state,
  input  mem_rd_rsp_t wgt_rsp,
  input  mem_rd_rsp_t bias_rsp,
  input  mem_rd_rsp_t pic_rsp,
  input  row_idx_t    kernel_row,
  output pix_t        out_byte
);

  logic [8*KER_ROWS*KER_COLS-1:0] wgt_blk;   // byte 4r+c is element (r,c)
  acc_t                           bias_q;
  pix_t [KER_COLS-1:0]            pix_row;
  wgt_t [KER_COLS-1:0]            wgt_row;
  acc_t                           dp_res;
  acc_t                           acc;
  acc_t                           sum;

  // operands held for the whole run
  always_ff @(posedge clk)
  begin
    if (wgt_rsp.valid)
      wgt_blk <= wgt_rsp.data[8*KER_ROWS*KER_COLS-1:0];
    if (bias_rsp.valid)
      bias_q <= bias_rsp.data[$bits(acc_t)-1:0];   // little endian word
  end

  // the dot product register samples the row in its valid cycle
  assign pix_row = pic_rsp.data[8*KER_COLS-1:0];
  assign wgt_row = wgt_blk[8*KER_COLS*kernel_row +: 8*KER_COLS];

  dot_product u_dp (
    .clk     (clk),
    .rst_n   (rst_n),
    .pix_row (pix_row),
    .wgt_row (wgt_row),
    .dp_res  (dp_res)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      acc <= '0;
    else if (state == CALC)
      acc <= acc + dp_res;               // dp_res is this row's product
    else if (state == ACT || state == IDLE)
      acc <= '0;                         // fresh window
  end

  // activation, clamp to 0..255
  assign sum = acc + bias_q;

  always_comb
  begin
    if (sum < 0)
      out_byte = '0;
    else if (sum > 32'sd255)
      out_byte = '1;
    else
      out_byte = sum[7:0];
  end

endmodule

// File: source/result_packer.sv
//====================================================================
// output byte packer
// fills write words from lane 0 upward, reports the byte count as the
// write size and walks the write address from the result base
//====================================================================
module result_packer import cnn_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cnn_state_t            state,
  input  addr_t                 sw_cnn_addr_z,
  input  pix_t                  out_byte,
  input  logic                  wr_ack,
  output addr_t                 wr_addr,
  output logic [8*WR_BYTES-1:0] wr_data,
  output addr_t                 wr_size,
  output logic                  word_full
);

  logic [$clog2(WR_BYTES):0] byte_cnt;   // 0 to WR_BYTES
  logic                      acked;

  assign acked     = (state == WRITE) & wr_ack;
  assign word_full = (byte_cnt == WR_BYTES - 1);   // this ACT byte fills lane 3
  assign wr_size   = addr_t'(byte_cnt);

  // count and address
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      byte_cnt <= '0;
      wr_addr  <= '0;
    end
    else if (state == IDLE)
    begin
      byte_cnt <= '0;
      wr_addr  <= sw_cnn_addr_z;   // restart each run
    end
    else if (state == ACT)
      byte_cnt <= byte_cnt + 1'b1;
    else if (acked)
    begin
      byte_cnt <= '0;
      wr_addr  <= wr_addr + wr_size;   // next word is contiguous
    end
  end

  // word data, unused lanes stay zero
  always_ff @(posedge clk)
  begin
    if (state == IDLE || acked)
      wr_data <= '0;
    else if (state == ACT)
      wr_data[8*byte_cnt +: 8] <= out_byte;
  end

endmodule

// File: source/cnn_ctrl_fsm.sv
//====================================================================
// run sequencer of the convolution engine
// owns the state machine, the weight and bias reads, the picture and
// write request levels and the busy and done reporting
//====================================================================
module cnn_ctrl_fsm import cnn_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sw_cnn_go,
  input  addr_t       sw_cnn_addr_y,
  input  addr_t       sw_cnn_addr_bias,
  input  logic        pic_rsp_valid,
  input  logic        wgt_rsp_valid,
  input  logic        bias_rsp_valid,
  input  logic        last_row,      // kernel row 3 in progress
  input  logic        last_window,   // bottom right window in progress
  input  logic        word_full,     // byte pushed in ACT completes a word
  input  logic        wr_ack,
  output cnn_state_t  state,
  output mem_rd_req_t wgt_rd,
  output mem_rd_req_t bias_rd,
  output logic        pic_req,
  output logic        wr_req,
  output logic        cnn_busy,
  output logic        cnn_done
);

  cnn_state_t nx_state;
  logic       wgt_got;     // kernel already returned this run
  logic       bias_got;
  logic       last_word;   // pending write closes the run
  logic       wgt_in;
  logic       bias_in;
  logic       run_end;

  assign wgt_in  = wgt_got | wgt_rsp_valid;
  assign bias_in = bias_got | bias_rsp_valid;
  assign run_end = (state == WRITE) & wr_ack & last_word;  // final ack

  //====================================================================
  // next state
  //====================================================================
  always_comb
  begin
    nx_state = state;
    case (state)
      IDLE:
        if (sw_cnn_go)
          nx_state = LOAD;
      LOAD:
        if (wgt_in && bias_in)   // both may land in the same cycle
          nx_state = READ;
      READ:
        if (pic_rsp_valid)
          nx_state = CALC;
      CALC:
        nx_state = last_row ? ACT : READ;
      ACT:
        nx_state = (word_full || last_window) ? WRITE : READ;
      WRITE:
        if (wr_ack)
          nx_state = last_word ? IDLE : READ;
      default:
        nx_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nx_state;
  end

  // per run bookkeeping
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wgt_got   <= 1'b0;
      bias_got  <= 1'b0;
      last_word <= 1'b0;
    end
    else if (state == IDLE)
    begin
      wgt_got   <= 1'b0;
      bias_got  <= 1'b0;
      last_word <= 1'b0;
    end
    else
    begin
      if (wgt_rsp_valid)
        wgt_got <= 1'b1;
      if (bias_rsp_valid)
        bias_got <= 1'b1;
      if (state == ACT && last_window)
        last_word <= 1'b1;   // 25th byte, partial word follows
    end
  end

  // read requests drop combinationally with their valid
  assign wgt_rd  = '{req:        (state == LOAD) & ~wgt_got & ~wgt_rsp_valid,
                     start_addr: sw_cnn_addr_y,
                     size_bytes: addr_t'(KER_ROWS * KER_COLS)};
  assign bias_rd = '{req:        (state == LOAD) & ~bias_got & ~bias_rsp_valid,
                     start_addr: sw_cnn_addr_bias,
                     size_bytes: addr_t'($bits(acc_t) / 8)};
  assign pic_req = (state == READ) & ~pic_rsp_valid;
  assign wr_req  = (state == WRITE);   // falls on the edge after ack

  // status to software
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnn_busy <= 1'b0;
      cnn_done <= 1'b0;
    end
    else
    begin
      cnn_done <= run_end;   // one cycle pulse
      if (state == IDLE && sw_cnn_go)
        cnn_busy <= 1'b1;
      else if (run_end)
        cnn_busy <= 1'b0;    // same edge as done
    end
  end

endmodule

// File: source/cnn.sv
//====================================================================
// convolution engine top level
// software gives four base addresses and a go pulse, the engine
// fetches its operands over three read ports and stores bytes over one
// write port, done pulses once the last word is acknowledged
//====================================================================
module cnn import cnn_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sw_cnn_go,
  input  addr_t       sw_cnn_addr_x,     // picture base
  input  addr_t       sw_cnn_addr_y,     // kernel base
  input  addr_t       sw_cnn_addr_bias,
  input  addr_t       sw_cnn_addr_z,     // result base
  output mem_rd_req_t pic_rd,
  output mem_rd_req_t wgt_rd,
  output mem_rd_req_t bias_rd,
  input  mem_rd_rsp_t pic_rsp,
  input  mem_rd_rsp_t wgt_rsp,
  input  mem_rd_rsp_t bias_rsp,
  output mem_wr_req_t wr,
  input  logic        wr_ack,
  output logic        cnn_busy,
  output logic        cnn_done
);

  cnn_state_t            state;
  logic                  pic_req;
  logic                  wr_req;
  logic                  last_row;
  logic                  last_window;
  logic                  word_full;
  addr_t                 pic_addr;
  row_idx_t              kernel_row;
  pix_t                  out_byte;
  addr_t                 wr_addr;
  addr_t                 wr_size;
  logic [8*WR_BYTES-1:0] wr_data;

  // request assembly, picture rows are always KER_COLS bytes
  assign pic_rd = '{req: pic_req, start_addr: pic_addr, size_bytes: addr_t'(KER_COLS)};
  assign wr     = '{req: wr_req, start_addr: wr_addr, size_bytes: wr_size, data: wr_data};

  cnn_ctrl_fsm u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .sw_cnn_go        (sw_cnn_go),
    .sw_cnn_addr_y    (sw_cnn_addr_y),
    .sw_cnn_addr_bias (sw_cnn_addr_bias),
    .pic_rsp_valid    (pic_rsp.valid),
    .wgt_rsp_valid    (wgt_rsp.valid),
    .bias_rsp_valid   (bias_rsp.valid),
    .last_row         (last_row),
    .last_window      (last_window),
    .word_full        (word_full),
    .wr_ack           (wr_ack),
    .state            (state),
    .wgt_rd           (wgt_rd),
    .bias_rd          (bias_rd),
    .pic_req          (pic_req),
    .wr_req           (wr_req),
    .cnn_busy         (cnn_busy),
    .cnn_done         (cnn_done)
  );

  window_counter u_win (
    .clk           (clk),
    .rst_n         (rst_n),
    .state         (state),
    .sw_cnn_addr_x (sw_cnn_addr_x),
    .pic_addr      (pic_addr),
    .kernel_row    (kernel_row),
    .last_row      (last_row),
    .last_window   (last_window)
  );

  conv_accum u_accum (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .wgt_rsp    (wgt_rsp),
    .bias_rsp   (bias_rsp),
    .pic_rsp    (pic_rsp),
    .kernel_row (kernel_row),
    .out_byte   (out_byte)
  );

  result_packer u_pack (
    .clk           (clk),
    .rst_n         (rst_n),
    .state         (state),
    .sw_cnn_addr_z (sw_cnn_addr_z),
    .out_byte      (out_byte),
    .wr_ack        (wr_ack),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_size       (wr_size),
    .word_full     (word_full)
  );

endmodule

// File: verification/tb_clk_gen.sv
//====================================================================
// free running testbench clock, 4 time unit period
// first rising edge at time 2
//====================================================================
module tb_clk_gen (
  output logic clk
);

  localparam int HALF = 2;   // half period

  initial
  begin
    clk = 1'b0;
    forever
      #HALF clk = ~clk;
  end

endmodule

// File: verification/cnn_props.sv
//====================================================================
// protocol properties of the convolution engine ports
// bound into every cnn instance by the testbench
//====================================================================
module cnn_props import cnn_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        sw_cnn_go,
  input mem_rd_req_t pic_rd,
  input mem_rd_req_t wgt_rd,
  input mem_rd_req_t bias_rd,
  input mem_rd_rsp_t pic_rsp,
  input mem_rd_rsp_t wgt_rsp,
  input mem_rd_rsp_t bias_rsp,
  input mem_wr_req_t wr,
  input logic        wr_ack,
  input logic        cnn_busy,
  input logic        cnn_done
);

  int   fail_cnt = 0;   // assertion failures so far
  logic any_req;

  assign any_req = pic_rd.req | wgt_rd.req | bias_rd.req | wr.req;

  //====================================================================
  // read and write handshakes
  //====================================================================
  pic_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pic_rd.req |=> pic_rsp.valid ||
      (pic_rd.req && $stable(pic_rd.start_addr) && $stable(pic_rd.size_bytes)))
    else
    begin
      fail_cnt++;
      $error("picture req dropped or changed before valid");
    end

  wgt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_rd.req |=> wgt_rsp.valid ||
      (wgt_rd.req && $stable(wgt_rd.start_addr) && $stable(wgt_rd.size_bytes)))
    else
    begin
      fail_cnt++;
      $error("weight req dropped or changed before valid");
    end

  bias_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bias_rd.req |=> bias_rsp.valid ||
      (bias_rd.req && $stable(bias_rd.start_addr) && $stable(bias_rd.size_bytes)))
    else
    begin
      fail_cnt++;
      $error("bias req dropped or changed before valid");
    end

  wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr.req && !wr_ack |=> wr.req && $stable(wr))
    else
    begin
      fail_cnt++;
      $error("write req dropped or changed before ack");
    end

  wr_release: assert property (@(posedge clk) disable iff (!rst_n)
    wr.req && wr_ack |=> !wr.req)
    else
    begin
      fail_cnt++;
      $error("write req still high after ack");
    end

  //====================================================================
  // busy and done
  //====================================================================
  busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    sw_cnn_go && !cnn_busy |=> cnn_busy)
    else
    begin
      fail_cnt++;
      $error("busy did not rise after go");
    end

  busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cnn_busy) |-> cnn_done)
    else
    begin
      fail_cnt++;
      $error("busy fell without done");
    end

  done_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    cnn_done |-> $past(wr_ack) && !cnn_busy)
    else
    begin
      fail_cnt++;
      $error("done not right after the last write ack");
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cnn_done |=> !cnn_done)
    else
    begin
      fail_cnt++;
      $error("done longer than one cycle");
    end

  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !cnn_busy |-> !any_req)
    else
    begin
      fail_cnt++;
      $error("memory request while not busy");
    end

endmodule

// File: verification/tb_cnn.sv
//====================================================================
// testbench of the convolution engine
// memory model with random latency and two runs with fresh data
// every output byte is compared with a reference convolution
//====================================================================
module tb_cnn import cnn_pkg::*; ();

  localparam int RUNS     = 2;
  localparam int PIC_REQS = NUM_OUT * KER_ROWS;
  localparam int WORDS    = (NUM_OUT + WR_BYTES - 1) / WR_BYTES;
  localparam int TIMEOUT  = RUNS * NUM_OUT * KER_ROWS * 12 + 200;   // generous per row read

  logic        clk;
  logic        rst_n;
  logic        sw_cnn_go;
  addr_t       sw_cnn_addr_x;
  addr_t       sw_cnn_addr_y;
  addr_t       sw_cnn_addr_bias;
  addr_t       sw_cnn_addr_z;
  mem_rd_req_t pic_rd;
  mem_rd_req_t wgt_rd;
  mem_rd_req_t bias_rd;
  mem_rd_rsp_t pic_rsp;
  mem_rd_rsp_t wgt_rsp;
  mem_rd_rsp_t bias_rsp;
  mem_wr_req_t wr;
  logic        wr_ack;
  logic        cnn_busy;
  logic        cnn_done;

  logic [7:0] mem [0:(1 << ADDR_W) - 1];   // byte wide memory
  pix_t       pic [IMG_ROWS * IMG_COLS];
  wgt_t       ker [KER_ROWS * KER_COLS];
  acc_t       bias;
  pix_t       exp_q [$];                   // reference bytes in window order
  string      test_name = "reset";
  int         pic_cnt;
  int         wgt_cnt;
  int         bias_cnt;
  int         word_cnt;
  int         byte_cnt;
  int         data_errs = 0;
  int         req_errs  = 0;

  tb_clk_gen u_clk (.clk(clk));

  cnn UUT (
    .clk(clk), .rst_n(rst_n), .sw_cnn_go(sw_cnn_go),
    .sw_cnn_addr_x(sw_cnn_addr_x), .sw_cnn_addr_y(sw_cnn_addr_y),
    .sw_cnn_addr_bias(sw_cnn_addr_bias), .sw_cnn_addr_z(sw_cnn_addr_z),
    .pic_rd(pic_rd), .wgt_rd(wgt_rd), .bias_rd(bias_rd),
    .pic_rsp(pic_rsp), .wgt_rsp(wgt_rsp), .bias_rsp(bias_rsp),
    .wr(wr), .wr_ack(wr_ack), .cnn_busy(cnn_busy), .cnn_done(cnn_done)
  );

  bind cnn cnn_props u_props (
    .clk(clk), .rst_n(rst_n), .sw_cnn_go(sw_cnn_go),
    .pic_rd(pic_rd), .wgt_rd(wgt_rd), .bias_rd(bias_rd),
    .pic_rsp(pic_rsp), .wgt_rsp(wgt_rsp), .bias_rsp(bias_rsp),
    .wr(wr), .wr_ack(wr_ack), .cnn_busy(cnn_busy), .cnn_done(cnn_done)
  );

  //====================================================================
  // helpers
  //====================================================================
  function automatic logic [RD_DATA_W-1:0] fetch(addr_t a, addr_t n);
    logic [RD_DATA_W-1:0] d;
    d = '0;
    for (int i = 0; i < RD_DATA_W / 8; i++)
      if (i < int'(n))
        d[8*i +: 8] = mem[a + addr_t'(i)];   // byte 0 lowest
    return d;
  endfunction

  task automatic wait_cycles(input int lo, input int hi);
    repeat ($urandom_range(hi, lo)) @(negedge clk);
  endtask

  task automatic expect_value(input string what, input int exp, input int act);
    assert (exp == act)
    else
    begin
      req_errs++;
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic score_byte(input pix_t act);
    pix_t exp;
    exp = exp_q.pop_front();
    assert (act == exp)
    else
    begin
      data_errs++;
      $display("MISMATCH %s byte %0d: expected %0d, actual %0d", test_name, byte_cnt, exp, act);
    end
    byte_cnt++;
  endtask

  task automatic verify_quiet(input string when);
    assert (!(pic_rd.req || wgt_rd.req || bias_rd.req || wr.req || cnn_busy || cnn_done))
    else
    begin
      req_errs++;
      $display("request, busy or done output high %s", when);
    end
  endtask

  //====================================================================
  // memory model with reads answered after 1..5 cycles and writes acked after 1..4
  //====================================================================
  initial
  begin : pic_port
    forever
    begin
      @(negedge clk);
      if (pic_rd.req)
      begin
        expect_value("pic addr", int'(sw_cnn_addr_x) + (pic_cnt / KER_ROWS % WIN_COLS) +
                     ((pic_cnt / KER_ROWS / WIN_COLS) + pic_cnt % KER_ROWS) * IMG_COLS,
                     int'(pic_rd.start_addr));
        expect_value("pic size", KER_COLS, int'(pic_rd.size_bytes));
        pic_cnt++;
        wait_cycles(1, 5);
        pic_rsp = '{valid: 1'b1, data: fetch(pic_rd.start_addr, pic_rd.size_bytes)};
        @(negedge clk);
        pic_rsp = '0;
      end
    end
  end

  initial
  begin : wgt_port
    forever
    begin
      @(negedge clk);
      if (wgt_rd.req)
      begin
        expect_value("weight addr", int'(sw_cnn_addr_y), int'(wgt_rd.start_addr));
        expect_value("weight size", 16, int'(wgt_rd.size_bytes));
        wgt_cnt++;
        wait_cycles(1, 5);
        wgt_rsp = '{valid: 1'b1, data: fetch(wgt_rd.start_addr, wgt_rd.size_bytes)};
        @(negedge clk);
        wgt_rsp = '0;
      end
    end
  end

  initial
  begin : bias_port
    forever
    begin
      @(negedge clk);
      if (bias_rd.req)
      begin
        expect_value("bias addr", int'(sw_cnn_addr_bias), int'(bias_rd.start_addr));
        expect_value("bias size", 4, int'(bias_rd.size_bytes));
        bias_cnt++;
        wait_cycles(1, 5);
        bias_rsp = '{valid: 1'b1, data: fetch(bias_rd.start_addr, bias_rd.size_bytes)};
        @(negedge clk);
        bias_rsp = '0;
      end
    end
  end

  initial
  begin : wr_port
    int n;
    forever
    begin
      @(negedge clk);
      if (wr.req)
      begin
        n = (NUM_OUT - byte_cnt < WR_BYTES) ? NUM_OUT - byte_cnt : WR_BYTES;  // tail is short
        expect_value("write addr", int'(sw_cnn_addr_z) + WR_BYTES * word_cnt,
                     int'(wr.start_addr));
        expect_value("write size", n, int'(wr.size_bytes));
        for (int i = 0; i < n; i++)
          score_byte(wr.data[8*i +: 8]);
        word_cnt++;
        wait_cycles(1, 4);
        wr_ack = 1'b1;
        @(negedge clk);
        wr_ack = 1'b0;
      end
    end
  end

  //====================================================================
  // one run fills memory, builds the reference and waits for done
  //====================================================================
  task automatic run_conv(input string name, input addr_t x, input addr_t y,
                          input addr_t b, input addr_t z, input int wmax, input int bmax);
    acc_t s;
    for (int i = 0; i < IMG_ROWS * IMG_COLS; i++)
    begin
      pic[i] = pix_t'($urandom);
      mem[x + addr_t'(i)] = pic[i];
    end
    for (int i = 0; i < KER_ROWS * KER_COLS; i++)
    begin
      ker[i] = wgt_t'(int'($urandom_range(2 * wmax, 0)) - wmax);   // signed spread
      mem[y + addr_t'(i)] = ker[i];
    end
    bias = acc_t'(int'($urandom_range(2 * bmax, 0)) - bmax);
    for (int i = 0; i < 4; i++)
      mem[b + addr_t'(i)] = bias[8*i +: 8];   // little endian

    // reference in row major window order
    exp_q.delete();
    for (int wy = 0; wy < WIN_ROWS; wy++)
      for (int wx = 0; wx < WIN_COLS; wx++)
      begin
        s = bias;
        for (int r = 0; r < KER_ROWS; r++)
          for (int c = 0; c < KER_COLS; c++)
            s += int'(pic[(wy + r) * IMG_COLS + wx + c]) * int'(ker[r * KER_COLS + c]);
        if (s < 0)
          exp_q.push_back(8'd0);
        else if (s > 255)
          exp_q.push_back(8'd255);   // saturate high
        else
          exp_q.push_back(pix_t'(s));
      end

    test_name = name;
    pic_cnt   = 0;
    wgt_cnt   = 0;
    bias_cnt  = 0;
    word_cnt  = 0;
    byte_cnt  = 0;
    sw_cnn_addr_x    = x;
    sw_cnn_addr_y    = y;
    sw_cnn_addr_bias = b;
    sw_cnn_addr_z    = z;
    sw_cnn_go        = 1'b1;
    @(negedge clk);
    sw_cnn_go = 1'b0;
    while (!cnn_done)
      @(negedge clk);

    expect_value("weight reads", 1, wgt_cnt);
    expect_value("bias reads", 1, bias_cnt);
    expect_value("picture reads", PIC_REQS, pic_cnt);
    expect_value("write words", WORDS, word_cnt);
    expect_value("output bytes", NUM_OUT, byte_cnt);
    repeat (3) @(negedge clk);
  endtask

  task automatic finish_run(input bit timed_out);
    int prop_errs;
    prop_errs = UUT.u_props.fail_cnt;
    $display("errors: data %0d, request %0d, assertion %0d", data_errs, req_errs, prop_errs);
    if (!timed_out && data_errs == 0 && req_errs == 0 && prop_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  endtask

  //====================================================================
  // main sequence and cycle limit
  //====================================================================
  initial
  begin
    void'($urandom(32'h8ecb1ff2));
    rst_n            = 1'b0;
    sw_cnn_go        = 1'b0;
    sw_cnn_addr_x    = '0;
    sw_cnn_addr_y    = '0;
    sw_cnn_addr_bias = '0;
    sw_cnn_addr_z    = '0;
    pic_rsp          = '0;
    wgt_rsp          = '0;
    bias_rsp         = '0;
    wr_ack           = 1'b0;
    repeat (8)
    begin
      @(negedge clk);
      verify_quiet("during reset");
    end
    rst_n = 1'b1;
    repeat (2)
    begin
      @(negedge clk);
      verify_quiet("right after reset");
    end
    run_conv("run1", 19'h00100, 19'h00200, 19'h00280, 19'h00400, 3, 300);
    run_conv("run2", 19'h51230, 19'h2a0f0, 19'h3c004, 19'h7ff00, 127, 3000);
    finish_run(1'b0);
  end

  initial
  begin : watchdog
    for (int n = 0; n < TIMEOUT; n++)
      @(posedge clk);
    $display("timeout, engine did not finish within %0d cycles", TIMEOUT);
    finish_run(1'b1);
  end

endmodule

// File: cnn.f
source/cnn_pkg.sv
source/dot_product.sv
source/window_counter.sv
source/conv_accum.sv
source/result_packer.sv
source/cnn_ctrl_fsm.sv
source/cnn.sv
verification/tb_clk_gen.sv
verification/cnn_props.sv
verification/tb_cnn.sv
